/* verilog.f */
logic/obstacle_pkg.sv
logic/obstacles_counter.sv
logic/best_score_keeper.sv
logic/score_display.sv
logic/obstacle_game_score.sv
tests/obstacle_game_score_asserts.sv
tests/obstacle_game_score_tb.sv

/* Makefile */
# Verilator build and run for the obstacle game score testbench.

TOP := obstacle_game_score_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
		--top-module $(TOP) -f verilog.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

/* tests/obstacle_game_score_tb.sv */
module obstacle_game_score_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import obstacle_pkg::*;

    localparam int CLEAR_TIME  = 6;
    localparam int REFRESH_DIV = 4;

    localparam int DONE_LIMIT = CLEAR_TIME + 10;
    localparam int SCAN_LIMIT = 2 * SCORE_DIGITS * REFRESH_DIV + 4;

    localparam int ACT_SPAWN = 0;
    localparam int ACT_NOISY = 1;
    localparam int ACT_MENU  = 2;
    localparam int ACT_START = 3;

    localparam logic [31:0] LFSR_SEED = 32'd95987;
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;

    typedef struct {
        string       name;
        int          action;
        int          count;
        logic        show_best;
        logic [15:0] exp_score;
        logic [15:0] exp_best;
    } test_row_t;

    logic        clk;
    logic        rst;
    logic        start;
    logic        done_in;
    logic        show_best;
    logic        done_out;
    score_word_u obstacles_counted;
    score_word_u best_score;
    seg_code_t   seg;
    logic [3:0]  an;

    test_row_t   rows[$];
    logic [31:0] lfsr_state = LFSR_SEED;
    score_word_u model_score;
    score_word_u model_best;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          done_pulses = 0;
    bit          timed_out = 1'b0;

    obstacle_game_score #(
        .CLEAR_TIME (CLEAR_TIME),
        .REFRESH_DIV(REFRESH_DIV)
    ) i_dut (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .done_in          (done_in),
        .show_best        (show_best),
        .done_out         (done_out),
        .obstacles_counted(obstacles_counted),
        .best_score       (best_score),
        .seg              (seg),
        .an               (an)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // done_out lasts one full cycle, so each pulse is seen at exactly one falling edge.
    always @(negedge clk) begin
        if (!rst && done_out) begin
            done_pulses <= done_pulses + 1;
        end
    end

    function automatic logic next_lfsr_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    function automatic int random_bits(input int width);
        int value;
        value = 0;
        for (int b = 0; b < width; b++) begin
            value = (value << 1) | int'(next_lfsr_bit());
        end
        return value;
    endfunction

    function automatic int bcd_to_int(input score_word_u word);
        int value;
        value = int'(word.digits.thousands) * 1000;
        value = value + int'(word.digits.hundreds) * 100;
        value = value + int'(word.digits.tens) * 10;
        value = value + int'(word.digits.ones);
        return value;
    endfunction

    function automatic score_word_u int_to_bcd(input int value);
        score_word_u word;
        word.digits.ones      = 4'(value % 10);
        word.digits.tens      = 4'((value / 10) % 10);
        word.digits.hundreds  = 4'((value / 100) % 10);
        word.digits.thousands = 4'((value / 1000) % 10);
        return word;
    endfunction

    // lit segments are listed active high as gfedcba and inverted for the board.
    function automatic seg_code_t expected_seg(input logic [3:0] digit);
        logic [6:0] lit;
        case (digit)
            4'd0:    lit = 7'b0111111;
            4'd1:    lit = 7'b0000110;
            4'd2:    lit = 7'b1011011;
            4'd3:    lit = 7'b1001111;
            4'd4:    lit = 7'b1100110;
            4'd5:    lit = 7'b1101101;
            4'd6:    lit = 7'b1111101;
            4'd7:    lit = 7'b0000111;
            4'd8:    lit = 7'b1111111;
            4'd9:    lit = 7'b1101111;
            default: lit = 7'b1000000;
        endcase
        return ~lit;
    endfunction

    function automatic logic [3:0] digit_of(input score_word_u word, input int position);
        logic [3:0] digit;
        case (position)
            0:       digit = word.digits.ones;
            1:       digit = word.digits.tens;
            2:       digit = word.digits.hundreds;
            default: digit = word.digits.thousands;
        endcase
        return digit;
    endfunction

    task automatic check_score(input string name, input score_word_u expected,
                               input score_word_u actual);
        if (actual.raw !== expected.raw) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected.raw, actual.raw);
            error_count++;
        end
    endtask

    task automatic check_segments(input string name, input seg_code_t expected,
                                  input seg_code_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_row(input string name, input int action, input int count,
                           input logic show, input logic [15:0] score,
                           input logic [15:0] best);
        test_row_t row;
        row.name      = name;
        row.action    = action;
        row.count     = count;
        row.show_best = show;
        row.exp_score = score;
        row.exp_best  = best;
        rows.push_back(row);
    endtask

    task automatic load_table();
        add_row("after_reset",     ACT_SPAWN, 0,    1'b0, 16'h0000, 16'h0000);
        add_row("first_strobe",    ACT_SPAWN, 1,    1'b0, 16'h0001, 16'h0001);
        add_row("ignored_strobes", ACT_NOISY, 3,    1'b0, 16'h0004, 16'h0004);
        add_row("reach_0009",      ACT_SPAWN, 5,    1'b1, 16'h0009, 16'h0009);
        add_row("carry_tens",      ACT_SPAWN, 1,    1'b0, 16'h0010, 16'h0010);
        add_row("reach_0099",      ACT_SPAWN, 89,   1'b0, 16'h0099, 16'h0099);
        add_row("carry_hundreds",  ACT_SPAWN, 1,    1'b1, 16'h0100, 16'h0100);
        add_row("menu_hold",       ACT_MENU,  0,    1'b0, 16'h0100, 16'h0100);
        add_row("menu_clear",      ACT_START, 0,    1'b0, 16'h0001, 16'h0100);
        add_row("lower_game",      ACT_SPAWN, 4,    1'b1, 16'h0005, 16'h0100);
        add_row("lower_game_view", ACT_SPAWN, 0,    1'b0, 16'h0005, 16'h0100);
        add_row("reach_9999",      ACT_SPAWN, 9994, 1'b0, 16'h9999, 16'h9999);
        add_row("wrap_to_zero",    ACT_SPAWN, 1,    1'b1, 16'h0000, 16'h9999);
        add_row("menu_after_wrap", ACT_MENU,  0,    1'b0, 16'h0000, 16'h9999);
        add_row("final_game",      ACT_START, 0,    1'b1, 16'h0001, 16'h9999);
    endtask

    // the caller raises the strobe or start, and cycles counts the rising edges
    // that follow the one which samples it.
    task automatic wait_done(input string name, input logic inject, input logic expect_clear,
                             output int cycles);
        cycles = -1;
        do begin
            @(negedge clk);
            cycles++;
            done_in = inject && (cycles == 1);
            if (expect_clear && cycles == 0) begin
                check_score({name, " cleared"}, int_to_bcd(0), obstacles_counted);
            end
        end while (!done_out && cycles < DONE_LIMIT);
        done_in = 1'b0;
        if (!done_out) begin
            $display("ERROR: test %s timed out, done_out did not rise within %0d cycles",
                     name, DONE_LIMIT);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic record_increment(input string name, input int cycles);
        check_count({name, " latency"}, CLEAR_TIME + 2, cycles);
        model_score = int_to_bcd((bcd_to_int(model_score) + 1) % 10000);
        if (bcd_to_int(model_score) > bcd_to_int(model_best)) begin
            model_best = model_score;
        end
        check_score({name, " score"}, model_score, obstacles_counted);
    endtask

    task automatic spawn_obstacle(input string name, input logic noisy);
        int   gap;
        int   cycles;
        logic inject;
        gap = random_bits(3);
        repeat (gap) @(negedge clk);
        inject = next_lfsr_bit() || noisy;
        done_in = 1'b1;
        wait_done(name, inject, 1'b0, cycles);
        if (!timed_out) begin
            record_increment(name, cycles);
        end
    endtask

    // a strobe sent while the menu is shown must not be counted.
    task automatic enter_menu(input string name);
        int hold;
        hold = random_bits(3) + 2;
        start = 1'b0;
        repeat (hold) @(negedge clk);
        done_in = 1'b1;
        @(negedge clk);
        done_in = 1'b0;
        repeat (CLEAR_TIME + 2) @(negedge clk);
        check_score({name, " held"}, model_score, obstacles_counted);
    endtask

    task automatic start_game(input string name);
        int cycles;
        start = 1'b1;
        wait_done(name, 1'b0, 1'b1, cycles);
        if (!timed_out) begin
            model_score = int_to_bcd(0);
            record_increment(name, cycles);
        end
    endtask

    task automatic scan_display(input string name, input score_word_u shown);
        logic [3:0] target;
        int         waited;
        for (int d = 0; d < SCORE_DIGITS; d++) begin
            target = ~(4'b0001 << d);
            waited = 0;
            while (an !== target && waited < SCAN_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (an !== target) begin
                $display("ERROR: test %s, anode pattern %b never appeared", name, target);
                error_count++;
                timed_out = 1'b1;
                return;
            end
            check_segments($sformatf("%s digit %0d", name, d),
                           expected_seg(digit_of(shown, d)), seg);
        end
    endtask

    task automatic run_row(input int index);
        test_row_t   row;
        int          errors_before;
        int          pulses_before;
        int          accepted;
        score_word_u exp_score;
        score_word_u exp_best;
        row = rows[index];
        errors_before = error_count;
        pulses_before = done_pulses;
        accepted = 0;
        show_best = row.show_best;
        case (row.action)
            ACT_MENU: begin
                enter_menu(row.name);
            end
            ACT_START: begin
                start_game(row.name);
                accepted++;
            end
            default: begin
                for (int n = 0; n < row.count && !timed_out; n++) begin
                    spawn_obstacle(row.name, row.action == ACT_NOISY);
                    accepted++;
                end
            end
        endcase

        // one cycle for the best score and one for the registered segments.
        repeat (2) @(negedge clk);
        exp_score.raw = row.exp_score;
        exp_best.raw  = row.exp_best;
        check_score({row.name, " score"}, exp_score, obstacles_counted);
        check_score({row.name, " best"}, exp_best, best_score);
        check_count({row.name, " done_out pulses"}, accepted, done_pulses - pulses_before);
        if (!timed_out) begin
            scan_display(row.name, row.show_best ? exp_best : exp_score);
        end

        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %-16s ok", row.name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", row.name,
                     error_count - errors_before);
        end
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b1;
        done_in     = 1'b0;
        show_best   = 1'b0;
        model_score = int_to_bcd(0);
        model_best  = int_to_bcd(0);
        load_table();

        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            run_row(i);
        end

        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, error_count,
                 i_dut.i_asserts.assertion_failures);
        if (error_count == 0 && i_dut.i_asserts.assertion_failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tests/obstacle_game_score_asserts.sv */
module obstacle_game_score_asserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      done_out,
    input logic [3:0]                an,
    input obstacle_pkg::score_word_u obstacles_counted,
    input obstacle_pkg::score_word_u best_score
);

    timeunit 1ns;
    timeprecision 1ps;

    int assertion_failures = 0;

    // a score increment is a single-cycle strobe.
    done_out_single: assert property (@(posedge clk) disable iff (rst)
        done_out |=> !done_out)
        else begin
            assertion_failures++;
            $error("done_out was high for two cycles in a row");
        end

    // the display scan drives exactly one active-low anode.
    one_anode_low: assert property (@(posedge clk) disable iff (rst)
        $countones(~an) == 1)
        else begin
            assertion_failures++;
            $error("anode pattern %b does not have exactly one bit low", an);
        end

    // the best score has caught up one cycle after each increment.
    best_not_below: assert property (@(posedge clk) disable iff (rst)
        done_out |=> (best_score.raw >= obstacles_counted.raw))
        else begin
            assertion_failures++;
            $error("best score %h is below score %h", best_score.raw, obstacles_counted.raw);
        end

endmodule

bind obstacle_game_score obstacle_game_score_asserts i_asserts (
    .clk              (clk),
    .rst              (rst),
    .done_out         (done_out),
    .an               (an),
    .obstacles_counted(obstacles_counted),
    .best_score       (best_score)
);

/* logic/obstacle_game_score.sv */
module obstacle_game_score #(
    parameter int CLEAR_TIME  = 65000000,
    parameter int REFRESH_DIV = 100000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      done_in,
    input  logic                      show_best,
    output logic                      done_out,
    output obstacle_pkg::score_word_u obstacles_counted,
    output obstacle_pkg::score_word_u best_score,
    output obstacle_pkg::seg_code_t   seg,
    output logic [3:0]                an
);

    import obstacle_pkg::*;

    score_word_u display_value;

    obstacles_counter #(
        .CLEAR_TIME(CLEAR_TIME)
    ) i_counter (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .done_in          (done_in),
        .done_out         (done_out),
        .obstacles_counted(obstacles_counted)
    );

    best_score_keeper i_best (
        .clk         (clk),
        .rst         (rst),
        .score_strobe(done_out),
        .score       (obstacles_counted),
        .best_score  (best_score)
    );

    // the player picks which score is on the display.
    assign display_value = show_best ? best_score : obstacles_counted;

    score_display #(
        .REFRESH_DIV(REFRESH_DIV)
    ) i_display (
        .clk  (clk),
        .rst  (rst),
        .value(display_value),
        .seg  (seg),
        .an   (an)
    );

endmodule

/* logic/score_display.sv */
module score_display #(
    parameter int REFRESH_DIV = 100000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  obstacle_pkg::score_word_u value,
    output obstacle_pkg::seg_code_t   seg,
    output logic [3:0]                an
);

    import obstacle_pkg::*;

    localparam int DIV_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(REFRESH_DIV - 1);
    localparam logic [1:0] LAST_IDX = 2'(SCORE_DIGITS - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       idx;
    logic [1:0]       idx_nxt;
    logic [1:0]       scan_sel;
    logic [3:0]       nibble;

    function automatic seg_code_t bcd_to_seg(input logic [3:0] bcd);
        seg_code_t code;
        case (bcd)
            4'd0:    code = SEG_0;
            4'd1:    code = SEG_1;
            4'd2:    code = SEG_2;
            4'd3:    code = SEG_3;
            4'd4:    code = SEG_4;
            4'd5:    code = SEG_5;
            4'd6:    code = SEG_6;
            4'd7:    code = SEG_7;
            4'd8:    code = SEG_8;
            4'd9:    code = SEG_9;
            default: code = SEG_DASH;
        endcase
        return code;
    endfunction

    always_comb begin
        idx_nxt = idx;
        if (div_cnt == DIV_LAST) begin
            idx_nxt = (idx == LAST_IDX) ? 2'd0 : idx + 2'd1;
        end
    end

    // during reset the ones digit is loaded so seg already matches the anode.
    always_comb begin
        scan_sel = rst ? 2'd0 : idx_nxt;
        case (scan_sel)
            2'd0:    nibble = value.digits.ones;
            2'd1:    nibble = value.digits.tens;
            2'd2:    nibble = value.digits.hundreds;
            default: nibble = value.digits.thousands;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            idx     <= 2'd0;
            an      <= 4'b1110;
        end else begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            idx     <= idx_nxt;
            an      <= ~(4'b0001 << idx_nxt);
        end
    end

    // refreshed every cycle, so a new score shows up one cycle later.
    always_ff @(posedge clk) begin
        seg <= bcd_to_seg(nibble);
    end

endmodule

/* logic/best_score_keeper.sv */
module best_score_keeper (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      score_strobe,
    input  obstacle_pkg::score_word_u score,
    output obstacle_pkg::score_word_u best_score
);

    logic new_record;

    // BCD digits are ordered like binary nibbles, so the raw compare is exact.
    always_comb begin
        new_record = score_strobe && (score.raw > best_score.raw);
    end

    // the best score survives menu visits and the clear at game start.
    always_ff @(posedge clk) begin
        if (rst) begin
            best_score.raw <= '0;
        end else if (new_record) begin
            best_score.raw <= score.raw;
        end
    end

endmodule

/* logic/obstacles_counter.sv */
module obstacles_counter #(
    parameter int CLEAR_TIME = 65000000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      done_in,
    output logic                      done_out,
    output obstacle_pkg::score_word_u obstacles_counted
);

    import obstacle_pkg::*;

    localparam int TIMER_W = (CLEAR_TIME > 0) ? $clog2(CLEAR_TIME + 1) : 1;
    localparam logic [TIMER_W-1:0] TIMER_MAX = TIMER_W'(CLEAR_TIME);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_COUNT = 2'd1;
    localparam logic [1:0] ST_DONE  = 2'd2;
    localparam logic [1:0] ST_MENU  = 2'd3;

    logic [1:0]         state;
    logic [1:0]         state_nxt;
    logic [TIMER_W-1:0] timer;
    logic [TIMER_W-1:0] timer_nxt;
    logic               done_nxt;
    bcd_digits_t        digits_nxt;

    always_comb begin
        state_nxt  = state;
        timer_nxt  = timer;
        done_nxt   = 1'b0;
        digits_nxt = obstacles_counted.digits;

        case (state)
            ST_IDLE: begin
                timer_nxt = '0;
                if (!start) begin
                    state_nxt = ST_MENU;
                end else if (done_in) begin
                    state_nxt = ST_COUNT;
                end
            end

            // strobes seen here are dropped, only one obstacle is timed at once.
            ST_COUNT: begin
                if (timer == TIMER_MAX) begin
                    state_nxt = ST_DONE;
                end else begin
                    timer_nxt = timer + 1'b1;
                end
            end

            ST_DONE: begin
                done_nxt  = 1'b1;
                state_nxt = ST_IDLE;

                // decimal carry chain, 9999 rolls over to 0000.
                if (digits_nxt.ones == 4'd9) begin
                    digits_nxt.ones = 4'd0;
                    if (digits_nxt.tens == 4'd9) begin
                        digits_nxt.tens = 4'd0;
                        if (digits_nxt.hundreds == 4'd9) begin
                            digits_nxt.hundreds = 4'd0;
                            if (digits_nxt.thousands == 4'd9) begin
                                digits_nxt.thousands = 4'd0;
                            end else begin
                                digits_nxt.thousands = digits_nxt.thousands + 4'd1;
                            end
                        end else begin
                            digits_nxt.hundreds = digits_nxt.hundreds + 4'd1;
                        end
                    end else begin
                        digits_nxt.tens = digits_nxt.tens + 4'd1;
                    end
                end else begin
                    digits_nxt.ones = digits_nxt.ones + 4'd1;
                end
            end

            // the score stays on show until a new game starts.
            // leaving the menu times the obstacle already on screen.
            ST_MENU: begin
                timer_nxt = '0;
                if (start) begin
                    digits_nxt = '0;
                    state_nxt  = ST_COUNT;
                end
            end

            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                 <= ST_IDLE;
            timer                 <= '0;
            done_out              <= 1'b0;
            obstacles_counted.raw <= '0;
        end else begin
            state                    <= state_nxt;
            timer                    <= timer_nxt;
            done_out                 <= done_nxt;
            obstacles_counted.digits <= digits_nxt;
        end
    end

endmodule

/* logic/obstacle_pkg.sv */
package obstacle_pkg;

    // number of digits on the seven-segment display.
    localparam int SCORE_DIGITS = 4;

    // one BCD digit per nibble, most significant digit at the top.
    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcd_digits_t;

    // the raw view is ordered like the decimal value, so an unsigned compare
    // of two raw words gives the same result as a compare of the scores.
    typedef union packed {
        logic [15:0] raw;
        bcd_digits_t digits;
    } score_word_u;

    // segment pattern, bit 6 is segment g and bit 0 is segment a, active low.
    typedef logic [6:0] seg_code_t;

    localparam seg_code_t SEG_0     = 7'b1000000;
    localparam seg_code_t SEG_1     = 7'b1111001;
    localparam seg_code_t SEG_2     = 7'b0100100;
    localparam seg_code_t SEG_3     = 7'b0110000;
    localparam seg_code_t SEG_4     = 7'b0011001;
    localparam seg_code_t SEG_5     = 7'b0010010;
    localparam seg_code_t SEG_6     = 7'b0000010;
    localparam seg_code_t SEG_7     = 7'b1111000;
    localparam seg_code_t SEG_8     = 7'b0000000;
    localparam seg_code_t SEG_9     = 7'b0010000;

    // shown for a nibble that is not a decimal digit.
    localparam seg_code_t SEG_DASH  = 7'b0111111;

endpackage
